// File: Bender.yml
package:
  name: mips_single_cycle

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mipsPkg.sv
      - core/mipsAlu.sv
      - core/mipsDecoder.sv
      - core/regFile.sv
      - core/pcUnit.sv
      - hdl/dataMem.sv
      - hdl/mipsTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/mipsTb.sv

// File: common/mipsPkg.sv
/* shared types of the single-cycle core
   ctrl_t is 13 bits and commit_t is 38 bits wide */
package mipsPkg;

  // data word, also used for byte addresses
  typedef logic [31:0] word_t;

  // register index, 32 registers
  typedef logic [4:0] regAddr_t;

  // instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;
  typedef logic [15:0] imm_t;

  // ==================================================
  // ALU operation select
  // ==================================================
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_SLT  = 4'd4,
    // result forced to zero
    ALU_NONE = 4'hF
  } aluOp_e;

  // ==================================================
  // decoded control, one per instruction
  // ==================================================
  typedef struct packed {
    // write rd instead of rt
    logic regDst;
    // second ALU operand from the immediate
    logic aluSrc;
    // write back from data memory
    logic memToReg;
    logic regWrite;
    logic memWrite;
    // beq, taken on ALU zero
    logic branch;
    // j and jal
    logic jump;
    // jal, writes r31
    logic link;
    // jr, next pc from rs
    logic regJump;
    aluOp_e aluOp;
  } ctrl_t;

  // ==================================================
  // commit trace, one register write per cycle
  // ==================================================
  typedef struct packed {
    logic valid;
    regAddr_t addr;
    word_t data;
  } commit_t;

endpackage

// File: common/mips_macros.svh
/* encodings for the supported MIPS subset only; no shifts or immediates beyond lw/sw
   data memory depth must stay a power of two */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ==================================================
// opcodes, instr[31:26]
// ==================================================
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ==================================================
// function codes, instr[5:0] of R-type
// ==================================================
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010
`define FN_JR  6'b001000

// jal writes its own address plus 8 into the link register
`define LINK_OFFSET 32'd8
`define LINK_REG    5'd31

// data memory words, 7-bit word index
`define DMEM_DEPTH 128

`endif

// File: core/mipsAlu.sv
/* slt compares signed; zero flag follows the result for every operation */
`timescale 1ns/1ps

module mipsAlu
  import mipsPkg::*;
(
  input  word_t  a,
  input  word_t  b,
  input  aluOp_e op,
  output word_t  result,
  output logic   zero
);

  // signed views for slt
  logic signed [31:0] aSigned;
  logic signed [31:0] bSigned;

  assign aSigned = a;
  assign bSigned = b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_SLT: begin
        // 1 when a < b as two's complement
        result = {31'd0, aSigned < bSigned};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // only meaningful to the pc unit when branch is set
  assign zero = (result == '0);

endmodule

// File: core/mipsDecoder.sv
/* unknown opcodes and unknown R-type function codes decode to an all-inactive ctrl
   jr is treated as R-type with no register write */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsDecoder
  import mipsPkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  // ==================================================
  // main control
  // ==================================================
  always_comb begin
    // default is a no-op
    ctrl = '{default: 1'b0, aluOp: ALU_NONE};

    case (opcode)
      `OP_RTYPE: begin
        // rd destination with both operands from registers
        ctrl.regDst = 1'b1;
        case (funct)
          `FN_ADD: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = ALU_ADD;
          end
          `FN_SUB: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = ALU_SUB;
          end
          `FN_AND: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = ALU_AND;
          end
          `FN_OR: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = ALU_OR;
          end
          `FN_SLT: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = ALU_SLT;
          end
          `FN_JR: begin
            // no write back and pc taken from rs
            ctrl.regJump = 1'b1;
          end
          default: begin
            ctrl.regDst = 1'b0;
          end
        endcase
      end
      `OP_LW: begin
        // address = rs + offset
        ctrl.aluSrc = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = ALU_ADD;
      end
      `OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp = ALU_ADD;
      end
      `OP_BEQ: begin
        // compare by subtraction so the zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp = ALU_SUB;
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      `OP_JAL: begin
        // link address into r31
        ctrl.jump = 1'b1;
        ctrl.link = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode keeps the no-op defaults
      end
    endcase
  end

endmodule

// File: core/pcUnit.sv
/* next pc priority is jump, taken branch, jr, then pc+4; no delay slot
   pc resets to 0 asynchronously */
`timescale 1ns/1ps

module pcUnit
  import mipsPkg::*;
#(
  parameter word_t LINK_OFFSET = 32'd8
) (
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  logic  zero,
  input  word_t instr,
  input  word_t rsData,
  output word_t pc,
  output word_t linkAddr
);

  word_t pcPlus4;
  word_t branchOff;
  word_t branchTarget;
  word_t jumpTarget;
  word_t nextPc;
  logic  branchTaken;

  assign pcPlus4 = pc + 32'd4;

  // 16-bit offset, sign extended, in words
  assign branchOff = {{14{instr[15]}}, instr[15:0], 2'b00};
  assign branchTarget = pcPlus4 + branchOff;

  // region of pc+4 with the 26-bit word target
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

  assign branchTaken = ctrl.branch & zero;

  // ==================================================
  // next address
  // ==================================================
  always_comb begin
    if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else if (ctrl.regJump) begin
      // jr uses the register value, not the field
      nextPc = rsData;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // return address for jal
  assign linkAddr = pc + LINK_OFFSET;

endmodule

// File: core/regFile.sv
/* r0 reads as zero and ignores writes; all registers clear on reset
   reads are combinational, so a write shows up on the next cycle only */
`timescale 1ns/1ps

module regFile
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  regAddr_t raddr1,
  input  regAddr_t raddr2,
  input  regAddr_t waddr,
  input  word_t    wdata,
  output word_t    rdata1,
  output word_t    rdata2
);

  word_t regs [32];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // ==================================================
  // read ports
  // ==================================================
  // r0 hardwired, independent of array contents
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: files.f
+incdir+common
common/mipsPkg.sv
core/mipsAlu.sv
core/mipsDecoder.sv
core/regFile.sv
core/pcUnit.sv
hdl/dataMem.sv
hdl/mipsTop.sv
testbench/mipsTb.sv

// File: hdl/dataMem.sv
/* word addressed; byte offset bits and bits above the index are ignored
   DEPTH must be a power of two */
`timescale 1ns/1ps

module dataMem
  import mipsPkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  we,
  input  word_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];
  logic [AW-1:0] wordIdx;

  // drop the byte offset
  assign wordIdx = addr[AW+1:2];

  // clocked write, whole array cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[wordIdx] <= wdata;
    end
  end

  // combinational read for lw in the same cycle
  assign rdata = mem[wordIdx];

endmodule

// File: hdl/mipsTop.sv
/* instruction memory is external and must answer instrAddr in the same cycle
   commit is combinational; sample it just before the rising clk */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsTop
  import mipsPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  word_t   instr,
  output word_t   instrAddr,
  output commit_t commit
);

  ctrl_t    ctrl;
  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;
  imm_t     imm;
  word_t    immExt;
  word_t    rdata1;
  word_t    rdata2;
  word_t    aluB;
  word_t    aluResult;
  logic     aluZero;
  word_t    memRdata;
  word_t    pc;
  word_t    linkAddr;
  regAddr_t waddr;
  word_t    wdata;
  logic     regWe;
  logic     memWe;

  // ==================================================
  // fetch and field split
  // ==================================================
  assign instrAddr = pc;
  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];
  assign imm = instr[15:0];
  assign immExt = {{16{imm[15]}}, imm};

  mipsDecoder decoder_i (
    .opcode (instr[31:26]),
    .funct  (instr[5:0]),
    .ctrl   (ctrl)
  );

  // writes held off while in reset
  assign regWe = ctrl.regWrite & rst;
  assign memWe = ctrl.memWrite & rst;

  regFile regFile_i (
    .clk    (clk),
    .rst    (rst),
    .we     (regWe),
    .raddr1 (rs),
    .raddr2 (rt),
    .waddr  (waddr),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // ==================================================
  // execute and memory
  // ==================================================
  assign aluB = ctrl.aluSrc ? immExt : rdata2;

  mipsAlu alu_i (
    .a      (rdata1),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  dataMem #(
    .DEPTH (`DMEM_DEPTH)
  ) dataMem_i (
    .clk   (clk),
    .rst   (rst),
    .we    (memWe),
    .addr  (aluResult),
    .wdata (rdata2),
    .rdata (memRdata)
  );

  pcUnit #(
    .LINK_OFFSET (`LINK_OFFSET)
  ) pcUnit_i (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .zero     (aluZero),
    .instr    (instr),
    .rsData   (rdata1),
    .pc       (pc),
    .linkAddr (linkAddr)
  );

  // ==================================================
  // write back and commit trace
  // ==================================================
  // r31 for jal, rd for R-type, rt for lw
  assign waddr = ctrl.link ? `LINK_REG : (ctrl.regDst ? rd : rt);

  // link beats memory beats ALU
  assign wdata = ctrl.link ? linkAddr : (ctrl.memToReg ? memRdata : aluResult);

  // r0 writes are never reported
  assign commit.valid = regWe && (waddr != '0);
  assign commit.addr = waddr;
  assign commit.data = wdata;

endmodule

// File: testbench/mipsTb.sv
/* plays the instruction memory from testbench/mips_vectors.txt, so run from the project root
   the program ends by running past its last word, where a self-jump is returned */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsTb
  import mipsPkg::*;
();

  localparam int MAX_WORDS = 256;

  logic    clk;
  logic    rst;
  word_t   instr;
  word_t   instrAddr;
  commit_t commit;

  // program image and expected register writes
  word_t   imem [MAX_WORDS];
  int      progLen;
  word_t   haltAddr;
  commit_t expectedQ [$];
  logic    loaded;

  int passCount;
  int failCount;
  int commitIdx;

  // ==================================================
  // clock and DUT
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  mipsTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .commit    (commit)
  );

  // instruction word at a byte address
  function automatic word_t fetchWord(input word_t addr);
    if ((addr[1:0] == 2'b00) && ((addr >> 2) < progLen)) begin
      return imem[addr >> 2];
    end
    // past the program the core parks on a jump to itself
    return {`OP_J, addr[27:2]};
  endfunction

  // ==================================================
  // vector file
  // ==================================================
  task automatic loadVectors();
    int      fd;
    int      rc;
    string   line;
    string   tag;
    int      regIdx;
    word_t   val;
    commit_t exp;
    fd = $fopen("testbench/mips_vectors.txt", "r");
    if (fd == 0) begin
      failCount++;
      $display("cannot open testbench/mips_vectors.txt from the current directory");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        tag = "";
        rc = $sscanf(line, "%s", tag);
        if (rc < 1) begin
          // blank line
        end else if (tag[0] == "#") begin
          // comment line
        end else if (tag == "I") begin
          rc = $sscanf(line, "%s %h", tag, val);
          if (progLen < MAX_WORDS) begin
            imem[progLen] = val;
          end
          progLen++;
        end else if (tag == "E") begin
          rc = $sscanf(line, "%s %d %h", tag, regIdx, val);
          exp.valid = 1'b1;
          exp.addr = regIdx[4:0];
          exp.data = val;
          expectedQ.push_back(exp);
        end else if (tag == "H") begin
          rc = $sscanf(line, "%s %h", tag, val);
          haltAddr = val;
        end else begin
          failCount++;
          $display("vector file has a line that is not understood: %s", line);
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic checkCommit(input string name, input commit_t expected, input commit_t actual);
    if ((actual.addr == expected.addr) && (actual.data == expected.data)) begin
      passCount++;
      $display("pass %s: r%0d = %08h", name, actual.addr, actual.data);
    end else begin
      failCount++;
      $display("error %s: expected r%0d = %08h, actual r%0d = %08h",
               name, expected.addr, expected.data, actual.addr, actual.data);
    end
  endtask

  task automatic checkPc(input string name, input word_t expected, input word_t actual);
    if (actual == expected) begin
      passCount++;
      $display("pass %s: pc = %08h", name, actual);
    end else begin
      failCount++;
      $display("error %s: expected pc %08h, actual pc %08h", name, expected, actual);
    end
  endtask

  // instruction memory answering on the falling edge
  initial begin
    forever begin
      @(negedge clk);
      instr = fetchWord(instrAddr);
    end
  end

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    commit_t seen;
    word_t   pcSeen;
    logic    running;
    rst = 1'b0;
    instr = '0;
    passCount = 0;
    failCount = 0;
    commitIdx = 0;
    progLen = 0;
    haltAddr = '0;
    loaded = 1'b0;
    loadVectors();

    // reset held for 3 cycles and released between edges
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    running = 1'b1;
    while (running) begin
      @(posedge clk);
      // pre-edge values of the instruction retiring now
      pcSeen = instrAddr;
      seen = commit;
      if (seen.valid) begin
        if (expectedQ.size() == 0) begin
          failCount++;
          $display("unexpected extra commit to r%0d with %08h at pc %08h",
                   seen.addr, seen.data, pcSeen);
        end else begin
          checkCommit($sformatf("commit_%0d", commitIdx), expectedQ.pop_front(), seen);
        end
        commitIdx++;
      end
      // left the program once the self-jump has run
      if ((pcSeen >> 2) >= progLen) begin
        running = 1'b0;
      end
    end

    @(negedge clk);
    checkPc("halt_pc", haltAddr, instrAddr);

    if (expectedQ.size() != 0) begin
      failCount++;
      $display("missing commits: %0d expected register writes never appeared",
               expectedQ.size());
    end else begin
      passCount++;
      $display("pass commit_count: all %0d expected writes seen", commitIdx);
    end

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ==================================================
  // watchdog
  // ==================================================
  initial begin
    int limit;
    wait (loaded === 1'b1);
    // 4 cycles per program word plus margin for reset
    limit = progLen * 4 + 50;
    repeat (limit) @(posedge clk);
    $display("timeout: the core did not reach the halt address within %0d cycles", limit);
    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: testbench/mips_vectors.txt
# I <word hex> program word in address order; E <reg dec> <data hex> expected write in retire order
# H <addr hex> halt address where the core parks; text after the fields is a note
I 00430820  0x00 add r1,r2,r3 (unwritten regs)
I 0C000005  0x04 jal 0x14
I 03FF4820  0x08 add r9,r31,r31 (never runs)
I 00A6A820  0x0C add r21,r5,r6 (jr returns here)
I 08000021  0x10 j 0x84
I 03FF1020  0x14 add r2,r31,r31
I 005F1820  0x18 add r3,r2,r31
I 00032022  0x1C sub r4,r0,r3
I AC020000  0x20 sw r2,0(r0)
I AC030004  0x24 sw r3,4(r0)
I AC040008  0x28 sw r4,8(r0)
I AC04020C  0x2C sw r4,0x20c(r0) aliases word 3
I 8C050000  0x30 lw r5,0(r0)
I 8C060004  0x34 lw r6,4(r0)
I 8C070008  0x38 lw r7,8(r0)
I 8C08040C  0x3C lw r8,0x40c(r0) aliases word 3
I 00A65020  0x40 add r10,r5,r6
I 00A65822  0x44 sub r11,r5,r6
I 00C76024  0x48 and r12,r6,r7
I 00A76825  0x4C or r13,r5,r7
I 00E5702A  0x50 slt r14,r7,r5
I 00A7782A  0x54 slt r15,r5,r7
I 00A60020  0x58 add r0,r5,r6 (no commit)
I 00068020  0x5C add r16,r0,r6
I 10A60001  0x60 beq r5,r6,+1 not taken
I 00A58820  0x64 add r17,r5,r5
I 10A50002  0x68 beq r5,r5,+2 taken
I 00A59020  0x6C add r18,r5,r5 (skipped)
I 00A59820  0x70 add r19,r5,r5 (skipped)
I 00C6A020  0x74 add r20,r6,r6
I 08000020  0x78 j 0x80
I 00C6B820  0x7C add r23,r6,r6 (skipped)
I 03E00008  0x80 jr r31
E 1 00000000  reset leaves r2 and r3 at zero
E 31 0000000C  jal address plus 8
E 2 00000018
E 3 00000024
E 4 FFFFFFDC  0 - 0x24
E 5 00000018
E 6 00000024
E 7 FFFFFFDC
E 8 FFFFFFDC  address bit 10 ignored
E 10 0000003C
E 11 FFFFFFF4  0x18 - 0x24
E 12 00000004
E 13 FFFFFFDC
E 14 00000001  -36 < 24 signed
E 15 00000000
E 16 00000024  r0 reads zero
E 17 00000030  after not-taken beq
E 20 00000048  after taken beq
E 21 0000003C  after jr
H 00000084
